//--- build.f
+incdir+src
src/ex_op_pkg.sv
src/ex_data_pkg.sv
src/ex_logic_shift.sv
src/ex_arith.sv
src/ex_mul_acc.sv
src/ex_hilo.sv
src/ex_result_sel.sv
src/ex_top.sv
testbench/tb_clock_gen.sv
testbench/ex_properties.sv
testbench/tb_ex_top.sv

//--- run.sh
#!/bin/sh
# build and run the execute stage regression with Verilator
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal --timescale 1ns/10ps \
  --top-module tb_ex_top -f build.f > build.log 2>&1 \
  || { echo "build failed, see build.log"; exit 1; }
./obj_dir/Vtb_ex_top +verilator+error+limit+100 > sim.log 2>&1
grep -q "^Regression passed$" sim.log && echo "simulation ok" \
  || { echo "simulation did not pass, see sim.log"; exit 1; }

//--- src/ex_arith.sv
// arithmetic unit: shared adder, compares, leading-bit counts, overflow and traps
`timescale 1ns/10ps
`include "ex_settings.svh"

module ex_arith
  import ex_op_pkg::*;
  import ex_data_pkg::*;
(
  input  alu_op_e aluop_i,
  input  word_t   reg1_i,
  input  word_t   reg2_i,
  output word_t   arith_res_o,
  output logic    ov_raw_o,
  output logic    trap_raw_o
);

  localparam int MSB   = `EX_WORD_W - 1;
  localparam int CNT_W = $clog2(`EX_WORD_W) + 1;

  logic                sub_en;
  logic                signed_cmp;
  word_t               addend_b;
  logic [`EX_WORD_W:0] sum_ext;
  word_t               sum;
  logic                carry;
  logic                reg1_lt_reg2;
  logic [CNT_W-1:0]    clz_cnt;
  logic [CNT_W-1:0]    clo_cnt;

  // zeros above the first set bit, 0 to word width
  function automatic logic [CNT_W-1:0] lead_zeros(input word_t v);
    logic [CNT_W-1:0] n;
    logic             found;
    n = '0;
    found = 1'b0;
    for (int i = MSB; i >= 0; i--)
    begin
      if (v[i])
        found = 1'b1;
      else if (!found)
        n = n + 1'b1;
    end
    return n;
  endfunction

  // every compare and subtract goes through the adder as reg1 + ~reg2 + 1
  assign sub_en = aluop_i inside {OP_SUB, OP_SUBU, OP_SLT, OP_SLTU,
                                  OP_TGE, OP_TGEU, OP_TLT, OP_TLTU};
  assign signed_cmp = aluop_i inside {OP_SLT, OP_TGE, OP_TLT};

  assign addend_b = sub_en ? ~reg2_i : reg2_i;
  assign sum_ext  = {1'b0, reg1_i} + {1'b0, addend_b} + {{`EX_WORD_W{1'b0}}, sub_en};
  assign sum      = sum_ext[MSB:0];
  assign carry    = sum_ext[`EX_WORD_W];

  // signed: differing signs decide, else the sign of the difference
  // unsigned: no carry out means a borrow
  assign reg1_lt_reg2 = signed_cmp ?
                        ((reg1_i[MSB] & ~reg2_i[MSB]) |
                         (~(reg1_i[MSB] ^ reg2_i[MSB]) & sum[MSB])) :
                        ~carry;

  assign clz_cnt = lead_zeros(reg1_i);
  assign clo_cnt = lead_zeros(~reg1_i);

  // trapping add/sub only
  assign ov_raw_o = (aluop_i inside {OP_ADD, OP_SUB}) &&
                    (reg1_i[MSB] == addend_b[MSB]) && (sum[MSB] != reg1_i[MSB]);

  always_comb
  begin
    case (aluop_i)
      OP_ADD, OP_ADDU, OP_SUB, OP_SUBU: arith_res_o = sum;
      OP_SLT, OP_SLTU: arith_res_o = {{MSB{1'b0}}, reg1_lt_reg2};
      OP_CLZ:  arith_res_o = {{(`EX_WORD_W-CNT_W){1'b0}}, clz_cnt};
      OP_CLO:  arith_res_o = {{(`EX_WORD_W-CNT_W){1'b0}}, clo_cnt};
      default: arith_res_o = '0;
    endcase
  end

  always_comb
  begin
    case (aluop_i)
      OP_TEQ:         trap_raw_o = (reg1_i == reg2_i);
      OP_TNE:         trap_raw_o = (reg1_i != reg2_i);
      OP_TGE, OP_TGEU: trap_raw_o = ~reg1_lt_reg2;
      OP_TLT, OP_TLTU: trap_raw_o = reg1_lt_reg2;
      default:        trap_raw_o = 1'b0;
    endcase
  end

endmodule

//--- src/ex_data_pkg.sv
// execute stage data types: words, hi/lo pairs and register numbers
package ex_data_pkg;

`include "ex_settings.svh"

  // one general register value
  typedef logic [`EX_WORD_W-1:0] word_t;

  // hi:lo pair, also a full product
  typedef logic [2*`EX_WORD_W-1:0] dword_t;

  // destination register number
  typedef logic [`EX_REG_ADDR_W-1:0] reg_addr_t;

endpackage

//--- src/ex_hilo.sv
// hi/lo unit: forwarding of hi:lo, move results and the hi/lo write request
`timescale 1ns/10ps

module ex_hilo
  import ex_op_pkg::*;
  import ex_data_pkg::*;
(
  input  logic    rst_n_i,
  input  alu_op_e aluop_i,
  input  word_t   reg1_i,
  input  word_t   hi_i,
  input  word_t   lo_i,
  input  word_t   mem_hi_i,
  input  word_t   mem_lo_i,
  input  logic    mem_whilo_i,
  input  word_t   wb_hi_i,
  input  word_t   wb_lo_i,
  input  logic    wb_whilo_i,
  input  dword_t  mul_hilo_i,
  input  logic    mul_hilo_we_i,
  output dword_t  hilo_fwd_o,
  output word_t   move_res_o,
  output word_t   hi_o,
  output word_t   lo_o,
  output logic    whilo_o
);

  localparam int W = $bits(word_t);

  word_t hi_fwd;
  word_t lo_fwd;
  logic  hilo_we;

  // memory stage is younger than write-back, so it wins
  always_comb
  begin
    if (mem_whilo_i)
      {hi_fwd, lo_fwd} = {mem_hi_i, mem_lo_i};
    else if (wb_whilo_i)
      {hi_fwd, lo_fwd} = {wb_hi_i, wb_lo_i};
    else
      {hi_fwd, lo_fwd} = {hi_i, lo_i};
  end

  assign hilo_fwd_o = {hi_fwd, lo_fwd};

  always_comb
  begin
    case (aluop_i)
      OP_MFHI:          move_res_o = hi_fwd;
      OP_MFLO:          move_res_o = lo_fwd;
      // condition was resolved in decode, only the value passes here
      OP_MOVZ, OP_MOVN: move_res_o = reg1_i;
      default:          move_res_o = '0;
    endcase
  end

  always_comb
  begin
    hilo_we = 1'b1;
    if (mul_hilo_we_i)
      {hi_o, lo_o} = mul_hilo_i;
    else if (aluop_i == OP_MTHI)
      {hi_o, lo_o} = {reg1_i, lo_fwd};
    else if (aluop_i == OP_MTLO)
      {hi_o, lo_o} = {hi_fwd, reg1_i};
    else
      begin
        hilo_we      = 1'b0;
        {hi_o, lo_o} = {2*W{1'b0}};
      end
  end

  assign whilo_o = rst_n_i & hilo_we;

endmodule

//--- src/ex_logic_shift.sv
// logic and shift unit: bitwise ops on both operands and shifts of reg2
`timescale 1ns/10ps
`include "ex_settings.svh"

module ex_logic_shift
  import ex_op_pkg::*;
  import ex_data_pkg::*;
(
  input  alu_op_e aluop_i,
  input  word_t   reg1_i,
  input  word_t   reg2_i,
  output word_t   logic_res_o,
  output word_t   shift_res_o
);

  logic [`EX_SHAMT_W-1:0] shamt;

  // shift amount sits in the low bits of reg1
  assign shamt = reg1_i[`EX_SHAMT_W-1:0];

  always_comb
  begin
    case (aluop_i)
      OP_OR:   logic_res_o = reg1_i | reg2_i;
      OP_AND:  logic_res_o = reg1_i & reg2_i;
      OP_NOR:  logic_res_o = ~(reg1_i | reg2_i);
      OP_XOR:  logic_res_o = reg1_i ^ reg2_i;
      default: logic_res_o = '0;
    endcase
  end

  always_comb
  begin
    case (aluop_i)
      OP_SLL:  shift_res_o = reg2_i << shamt;
      OP_SRL:  shift_res_o = reg2_i >> shamt;
      // sign bit of reg2 fills from the left
      OP_SRA:  shift_res_o = word_t'($signed(reg2_i) >>> shamt);
      default: shift_res_o = '0;
    endcase
  end

endmodule

//--- src/ex_mul_acc.sv
// multiplier with two-cycle multiply-accumulate sequencer and stall request
`timescale 1ns/10ps
`include "ex_settings.svh"

module ex_mul_acc
  import ex_op_pkg::*;
  import ex_data_pkg::*;
(
  input  logic    clk,
  input  logic    rst_n_i,
  input  alu_op_e aluop_i,
  input  word_t   reg1_i,
  input  word_t   reg2_i,
  input  dword_t  hilo_fwd_i,
  output word_t   mul_lo_o,
  output dword_t  mul_hilo_o,
  output logic    mul_hilo_we_o,
  output logic    stall_o
);

  localparam int MSB = `EX_WORD_W - 1;

  logic                    sign_op;
  logic                    is_acc;
  logic                    is_msub;
  logic [`EX_WORD_W:0]     op_a;
  logic [`EX_WORD_W:0]     op_b;
  logic [2*`EX_WORD_W+1:0] prod_full;
  dword_t                  product;
  logic                    acc_start;
  logic                    acc_busy;
  dword_t                  acc_prod;

  assign sign_op = aluop_i inside {OP_MULT, OP_MUL, OP_MADD, OP_MSUB};
  assign is_acc  = aluop_i inside {OP_MADD, OP_MADDU, OP_MSUB, OP_MSUBU};
  assign is_msub = aluop_i inside {OP_MSUB, OP_MSUBU};

  // one extra bit lets a single signed multiplier serve both kinds
  assign op_a      = {sign_op & reg1_i[MSB], reg1_i};
  assign op_b      = {sign_op & reg2_i[MSB], reg2_i};
  assign prod_full = $signed(op_a) * $signed(op_b);
  assign product   = prod_full[2*`EX_WORD_W-1:0];

  assign mul_lo_o = product[MSB:0];

  // first accumulate cycle, sequencer still idle
  assign acc_start = is_acc & ~acc_busy;
  assign stall_o   = rst_n_i & acc_start;

  // busy lasts exactly one cycle
  always_ff @(posedge clk)
  begin
    if (!rst_n_i)
      acc_busy <= 1'b0;
    else if (acc_busy)
      acc_busy <= 1'b0;
    else if (acc_start)
      acc_busy <= 1'b1;
  end

  // partial product, already negated for the subtracting forms
  always_ff @(posedge clk)
  begin
    if (acc_start)
      acc_prod <= is_msub ? (~product + 1'b1) : product;
  end

  always_comb
  begin
    mul_hilo_o    = product;
    mul_hilo_we_o = 1'b0;
    if (acc_busy)
      begin
        // second cycle: fold in the freshest hi:lo
        mul_hilo_o    = acc_prod + hilo_fwd_i;
        mul_hilo_we_o = is_acc;
      end
    else if (aluop_i inside {OP_MULT, OP_MULTU})
      begin
        mul_hilo_we_o = 1'b1;
      end
  end

endmodule

//--- src/ex_op_pkg.sv
// execute stage operation codes and result classes as decoded upstream
package ex_op_pkg;

`include "ex_settings.svh"

  typedef enum logic [`EX_ALUOP_W-1:0] {
    OP_NOP   = 8'b0000_0000,
    // logic
    OP_OR    = 8'b0010_0101,
    OP_AND   = 8'b0010_0100,
    OP_NOR   = 8'b0010_0111,
    OP_XOR   = 8'b0010_0110,
    // shifts
    OP_SLL   = 8'b0111_1100,
    OP_SRL   = 8'b0000_0010,
    OP_SRA   = 8'b0000_0011,
    // arithmetic and compares
    OP_ADD   = 8'b0010_0000,
    OP_ADDU  = 8'b0010_0001,
    OP_SUB   = 8'b0010_0010,
    OP_SUBU  = 8'b0010_0011,
    OP_SLT   = 8'b0010_1010,
    OP_SLTU  = 8'b0010_1011,
    OP_CLZ   = 8'b1011_0000,
    OP_CLO   = 8'b1011_0001,
    // traps
    OP_TEQ   = 8'b0011_0100,
    OP_TNE   = 8'b0011_0110,
    OP_TGE   = 8'b0011_0000,
    OP_TGEU  = 8'b0011_0001,
    OP_TLT   = 8'b0011_0010,
    OP_TLTU  = 8'b0011_0011,
    // hi/lo moves and conditional moves
    OP_MFHI  = 8'b0001_0000,
    OP_MFLO  = 8'b0001_0010,
    OP_MTHI  = 8'b0001_0001,
    OP_MTLO  = 8'b0001_0011,
    OP_MOVZ  = 8'b0000_1010,
    OP_MOVN  = 8'b0000_1011,
    // multiplies
    OP_MULT  = 8'b0001_1000,
    OP_MULTU = 8'b0001_1001,
    OP_MUL   = 8'b1010_1001,
    // two-cycle multiply-accumulate
    OP_MADD  = 8'b1010_0110,
    OP_MADDU = 8'b1010_1000,
    OP_MSUB  = 8'b1010_1010,
    OP_MSUBU = 8'b1010_1011
  } alu_op_e;

  typedef enum logic [`EX_ALUSEL_W-1:0] {
    SEL_NOP   = 3'b000,
    SEL_LOGIC = 3'b001,
    SEL_SHIFT = 3'b010,
    SEL_MOVE  = 3'b011,
    SEL_ARITH = 3'b100,
    SEL_MUL   = 3'b101
  } alu_sel_e;

endpackage

//--- src/ex_result_sel.sv
// result select: write data by result class, write gating and exception flags
`timescale 1ns/10ps

module ex_result_sel
  import ex_op_pkg::*;
  import ex_data_pkg::*;
(
  input  logic      rst_n_i,
  input  alu_sel_e  alusel_i,
  input  reg_addr_t wd_i,
  input  logic      wreg_i,
  input  word_t     logic_res_i,
  input  word_t     shift_res_i,
  input  word_t     move_res_i,
  input  word_t     arith_res_i,
  input  word_t     mul_lo_i,
  input  logic      ov_raw_i,
  input  logic      trap_raw_i,
  output reg_addr_t wd_o,
  output logic      wreg_o,
  output word_t     wdata_o,
  output logic      ov_o,
  output logic      trap_o
);

  assign wd_o = wd_i;

  always_comb
  begin
    case (alusel_i)
      SEL_LOGIC: wdata_o = logic_res_i;
      SEL_SHIFT: wdata_o = shift_res_i;
      SEL_MOVE:  wdata_o = move_res_i;
      SEL_ARITH: wdata_o = arith_res_i;
      // mul writes only the low word to the register file
      SEL_MUL:   wdata_o = mul_lo_i;
      default:   wdata_o = '0;
    endcase
  end

  // an overflowing add/sub must not reach the register file
  assign wreg_o = rst_n_i & wreg_i & ~ov_raw_i;

  assign ov_o   = rst_n_i & ov_raw_i;
  assign trap_o = rst_n_i & trap_raw_i;

endmodule

//--- src/ex_settings.svh
// execute stage settings: widths shared by the packages and the datapath
`ifndef EX_SETTINGS_SVH
`define EX_SETTINGS_SVH

// data word of the pipeline
`define EX_WORD_W 32

// general register file has 32 entries
`define EX_REG_ADDR_W 5

// operation code from decode
`define EX_ALUOP_W 8

// result class from decode
`define EX_ALUSEL_W 3

// shift amount taken from the low bits of reg1
`define EX_SHAMT_W 5

`endif

//--- src/ex_top.sv
// execute stage top: connects the logic, arithmetic, multiply, hi/lo and select units
`timescale 1ns/10ps

module ex_top
  import ex_op_pkg::*;
  import ex_data_pkg::*;
(
  input  logic      clk,
  input  logic      rst_n_i,
  // from decode
  input  alu_op_e   aluop_i,
  input  alu_sel_e  alusel_i,
  input  word_t     reg1_i,
  input  word_t     reg2_i,
  input  reg_addr_t wd_i,
  input  logic      wreg_i,
  // hi/lo register and its forwarding paths
  input  word_t     hi_i,
  input  word_t     lo_i,
  input  word_t     mem_hi_i,
  input  word_t     mem_lo_i,
  input  logic      mem_whilo_i,
  input  word_t     wb_hi_i,
  input  word_t     wb_lo_i,
  input  logic      wb_whilo_i,
  // to memory stage and pipeline control
  output reg_addr_t wd_o,
  output logic      wreg_o,
  output word_t     wdata_o,
  output word_t     hi_o,
  output word_t     lo_o,
  output logic      whilo_o,
  output logic      stall_o,
  output logic      ov_o,
  output logic      trap_o
);

  word_t  logic_res;
  word_t  shift_res;
  word_t  arith_res;
  logic   ov_raw;
  logic   trap_raw;
  dword_t hilo_fwd;
  word_t  move_res;
  word_t  mul_lo;
  dword_t mul_hilo;
  logic   mul_hilo_we;

  ex_logic_shift u_logic_shift (
    .aluop_i(aluop_i), .reg1_i(reg1_i), .reg2_i(reg2_i),
    .logic_res_o(logic_res), .shift_res_o(shift_res)
  );

  ex_arith u_arith (
    .aluop_i(aluop_i), .reg1_i(reg1_i), .reg2_i(reg2_i),
    .arith_res_o(arith_res), .ov_raw_o(ov_raw), .trap_raw_o(trap_raw)
  );

  ex_mul_acc u_mul_acc (
    .clk(clk), .rst_n_i(rst_n_i), .aluop_i(aluop_i),
    .reg1_i(reg1_i), .reg2_i(reg2_i), .hilo_fwd_i(hilo_fwd),
    .mul_lo_o(mul_lo), .mul_hilo_o(mul_hilo),
    .mul_hilo_we_o(mul_hilo_we), .stall_o(stall_o)
  );

  ex_hilo u_hilo (
    .rst_n_i(rst_n_i), .aluop_i(aluop_i), .reg1_i(reg1_i),
    .hi_i(hi_i), .lo_i(lo_i),
    .mem_hi_i(mem_hi_i), .mem_lo_i(mem_lo_i), .mem_whilo_i(mem_whilo_i),
    .wb_hi_i(wb_hi_i), .wb_lo_i(wb_lo_i), .wb_whilo_i(wb_whilo_i),
    .mul_hilo_i(mul_hilo), .mul_hilo_we_i(mul_hilo_we),
    .hilo_fwd_o(hilo_fwd), .move_res_o(move_res),
    .hi_o(hi_o), .lo_o(lo_o), .whilo_o(whilo_o)
  );

  ex_result_sel u_result_sel (
    .rst_n_i(rst_n_i), .alusel_i(alusel_i), .wd_i(wd_i), .wreg_i(wreg_i),
    .logic_res_i(logic_res), .shift_res_i(shift_res), .move_res_i(move_res),
    .arith_res_i(arith_res), .mul_lo_i(mul_lo),
    .ov_raw_i(ov_raw), .trap_raw_i(trap_raw),
    .wd_o(wd_o), .wreg_o(wreg_o), .wdata_o(wdata_o), .ov_o(ov_o), .trap_o(trap_o)
  );

endmodule

//--- testbench/ex_properties.sv
// multiply-accumulate sequencer checks, bound into every ex_mul_acc instance
`timescale 1ns/10ps

module ex_properties (
  input logic clk,
  input logic rst_n_i,
  input logic stall_i,
  input logic hilo_we_i
);

  // failed assertions, read by the testbench at the end of the run
  int fail_cnt = 0;

  // sequencer is busy for exactly one cycle after a stall
  stall_one_cycle: assert property (@(posedge clk) disable iff (!rst_n_i)
    stall_i |=> !stall_i)
    else
    begin
      $error("stall_o high in two consecutive cycles");
      fail_cnt++;
    end

  // hi/lo is written only after the stall cycle
  no_write_in_stall: assert property (@(posedge clk) disable iff (!rst_n_i)
    !(stall_i && hilo_we_i))
    else
    begin
      $error("hi/lo write request during a stall cycle");
      fail_cnt++;
    end

  stall_low_after_reset: assert property (@(posedge clk) $rose(rst_n_i) |-> !stall_i)
    else
    begin
      $error("stall_o high right after reset release");
      fail_cnt++;
    end

endmodule

bind ex_mul_acc ex_properties u_ex_properties (
  .clk(clk), .rst_n_i(rst_n_i), .stall_i(stall_o), .hilo_we_i(mul_hilo_we_o)
);

//--- testbench/tb_clock_gen.sv
// testbench clock source, free running at a fixed period
`timescale 1ns/10ps

module tb_clock_gen #(
  parameter int PERIOD_NS = 40
) (
  output logic clk_o
);

  initial
  begin
    clk_o = 1'b0;
  end

  // half period low, half high
  always #(PERIOD_NS / 2) clk_o = ~clk_o;

endmodule

//--- testbench/tb_ex_top.sv
// execute stage testbench: directed tests against a reference model of the stage
`timescale 1ns/10ps

module tb_ex_top
  import ex_op_pkg::*;
  import ex_data_pkg::*;
();

  localparam int CLK_PERIOD   = 40;
  localparam int RESET_CYCLES = 16;
  localparam int N_RAND       = 4;
  // reset and release, alu, overflow, traps, mul and hi/lo, accumulate
  localparam int TEST_CYCLES   = RESET_CYCLES + 1 + 15 * N_RAND + 4 + 6 + 18 + 26 + 9;
  localparam int MARGIN_CYCLES = 40;

  logic      clk;
  logic      rst_n;
  alu_op_e   aluop;
  alu_sel_e  alusel;
  word_t     reg1;
  word_t     reg2;
  reg_addr_t wd;
  logic      wreg;
  word_t     hi;
  word_t     lo;
  word_t     mem_hi;
  word_t     mem_lo;
  logic      mem_whilo;
  word_t     wb_hi;
  word_t     wb_lo;
  logic      wb_whilo;
  reg_addr_t wd_out;
  logic      wreg_out;
  word_t     wdata;
  word_t     hi_out;
  word_t     lo_out;
  logic      whilo;
  logic      stall;
  logic      ov;
  logic      trap;

  tb_clock_gen #(.PERIOD_NS(CLK_PERIOD)) u_clock_gen (.clk_o(clk));

  ex_top u_ex_top (
    .clk(clk), .rst_n_i(rst_n), .aluop_i(aluop), .alusel_i(alusel),
    .reg1_i(reg1), .reg2_i(reg2), .wd_i(wd), .wreg_i(wreg), .hi_i(hi), .lo_i(lo),
    .mem_hi_i(mem_hi), .mem_lo_i(mem_lo), .mem_whilo_i(mem_whilo),
    .wb_hi_i(wb_hi), .wb_lo_i(wb_lo), .wb_whilo_i(wb_whilo),
    .wd_o(wd_out), .wreg_o(wreg_out), .wdata_o(wdata), .hi_o(hi_out), .lo_o(lo_out),
    .whilo_o(whilo), .stall_o(stall), .ov_o(ov), .trap_o(trap)
  );

  task automatic report_mismatch(input string msg);
    $display("FAIL at %0t ns: %s", $time, msg);
    $display("Regression failed");
    $fatal(1, "stopping at first mismatch");
  endtask

  task automatic check_word(input string what, input word_t got, input word_t exp);
    if (got !== exp)
      report_mismatch($sformatf("%s got %h, expected %h", what, got, exp));
  endtask

  task automatic check_dword(input string what, input dword_t got, input dword_t exp);
    if (got !== exp)
      report_mismatch($sformatf("%s got %h, expected %h", what, got, exp));
  endtask

  task automatic check_flag(input string what, input logic got, input logic exp);
    if (got !== exp)
      report_mismatch($sformatf("%s got %b, expected %b", what, got, exp));
  endtask

  task automatic check_addr(input string what, input reg_addr_t got,
                            input reg_addr_t exp);
    if (got !== exp)
      report_mismatch($sformatf("%s got %0d, expected %0d", what, got, exp));
  endtask

  // result class as decode would give it
  function automatic alu_sel_e class_of(input alu_op_e op);
    case (op)
      OP_OR, OP_AND, OP_NOR, OP_XOR: return SEL_LOGIC;
      OP_SLL, OP_SRL, OP_SRA: return SEL_SHIFT;
      OP_MFHI, OP_MFLO, OP_MOVZ, OP_MOVN: return SEL_MOVE;
      OP_ADD, OP_ADDU, OP_SUB, OP_SUBU, OP_SLT, OP_SLTU, OP_CLZ, OP_CLO: return SEL_ARITH;
      OP_MUL: return SEL_MUL;
      default: return SEL_NOP;
    endcase
  endfunction

  function automatic word_t model_alu(input alu_op_e op, input word_t a, input word_t b);
    word_t r;
    int    n;
    r = '0;
    n = 0;
    case (op)
      OP_OR:  r = a | b;
      OP_AND: r = a & b;
      OP_NOR: r = ~(a | b);
      OP_XOR: r = a ^ b;
      OP_SLL: r = b << a[4:0];
      OP_SRL: r = b >> a[4:0];
      // logical shift, then the vacated top bits take the sign
      OP_SRA: r = (b >> a[4:0]) | (b[31] ? ~(32'hffff_ffff >> a[4:0]) : 32'h0);
      OP_ADD, OP_ADDU: r = a + b;
      OP_SUB, OP_SUBU: r = a - b;
      OP_SLT:  r = {31'b0, $signed(a) < $signed(b)};
      OP_SLTU: r = {31'b0, a < b};
      OP_CLZ:
      begin
        while (n < 32 && !a[31 - n])
          n++;
        r = n;
      end
      OP_CLO:
      begin
        while (n < 32 && a[31 - n])
          n++;
        r = n;
      end
      default: r = '0;
    endcase
    return r;
  endfunction

  // true signed result does not survive truncation to one word
  function automatic logic model_ov(input alu_op_e op, input word_t a, input word_t b);
    longint r;
    r = 0;
    if (op == OP_ADD)
      r = longint'($signed(a)) + longint'($signed(b));
    else if (op == OP_SUB)
      r = longint'($signed(a)) - longint'($signed(b));
    return r != {{32{r[31]}}, r[31:0]};
  endfunction

  function automatic logic model_trap(input alu_op_e op, input word_t a, input word_t b);
    case (op)
      OP_TEQ:  return a == b;
      OP_TNE:  return a != b;
      OP_TGE:  return $signed(a) >= $signed(b);
      OP_TGEU: return a >= b;
      OP_TLT:  return $signed(a) < $signed(b);
      OP_TLTU: return a < b;
      default: return 1'b0;
    endcase
  endfunction

  function automatic dword_t model_prod(input logic signed_mode, input word_t a,
                                        input word_t b);
    if (signed_mode)
      return dword_t'(longint'($signed(a)) * longint'($signed(b)));
    else
      return {32'b0, a} * {32'b0, b};
  endfunction

  // memory stage first, then write-back, then the register
  function automatic dword_t model_fwd();
    if (mem_whilo)
      return {mem_hi, mem_lo};
    else if (wb_whilo)
      return {wb_hi, wb_lo};
    else
      return {hi, lo};
  endfunction

  task automatic apply_op(input alu_op_e op, input word_t a, input word_t b,
                          input logic we = 1'b1);
    @(posedge clk);
    aluop  <= op;
    alusel <= class_of(op);
    reg1   <= a;
    reg2   <= b;
    wd     <= reg_addr_t'($urandom);
    wreg   <= we;
    @(negedge clk);
  endtask

  task automatic hold_cycle();
    @(posedge clk);
    @(negedge clk);
  endtask

  task automatic drive_hilo_sources(input logic mem_we, input logic wb_we);
    @(posedge clk);
    hi        <= $urandom;
    lo        <= $urandom;
    mem_hi    <= $urandom;
    mem_lo    <= $urandom;
    wb_hi     <= $urandom;
    wb_lo     <= $urandom;
    mem_whilo <= mem_we;
    wb_whilo  <= wb_we;
    @(negedge clk);
  endtask

  task automatic check_alu(input alu_op_e op, input word_t a, input word_t b);
    check_word($sformatf("%s wdata_o", op.name()), wdata, model_alu(op, a, b));
    check_flag($sformatf("%s ov_o", op.name()), ov, model_ov(op, a, b));
    check_flag($sformatf("%s wreg_o", op.name()), wreg_out, wreg & ~model_ov(op, a, b));
    check_addr($sformatf("%s wd_o", op.name()), wd_out, wd);
  endtask

  task automatic test_reset_quiet();
    for (int i = 0; i < RESET_CYCLES; i++)
    begin
      @(posedge clk);
      rst_n <= 1'b0;
      wreg  <= 1'b1;
      reg1  <= 32'h7fff_ffff;
      // accumulate, overflowing add and a taken trap in turn
      aluop <= (i % 3 == 0) ? OP_MADD : ((i % 3 == 1) ? OP_ADD : OP_TNE);
      reg2  <= 32'h0000_0001;
      @(negedge clk);
      check_flag("wreg_o in reset", wreg_out, 1'b0);
      check_flag("whilo_o in reset", whilo, 1'b0);
      check_flag("stall_o in reset", stall, 1'b0);
      check_flag("ov_o in reset", ov, 1'b0);
      check_flag("trap_o in reset", trap, 1'b0);
    end
    @(posedge clk);
    rst_n  <= 1'b1;
    aluop  <= OP_NOP;
    alusel <= SEL_NOP;
  endtask

  task automatic test_alu();
    alu_op_e ops [15];
    word_t   a;
    word_t   b;
    ops = '{OP_OR, OP_AND, OP_NOR, OP_XOR, OP_SLL, OP_SRL, OP_SRA, OP_ADD, OP_ADDU,
            OP_SUB, OP_SUBU, OP_SLT, OP_SLTU, OP_CLZ, OP_CLO};
    for (int k = 0; k < 15; k++)
      for (int n = 0; n < N_RAND; n++)
      begin
        a = $urandom;
        b = $urandom;
        // register write request alternates so wreg_o must follow it
        apply_op(ops[k], a, b, n[0]);
        check_alu(ops[k], a, b);
      end
    // leading-bit counts at both ends of the range
    for (int k = 0; k < 4; k++)
    begin
      a = (k % 2 == 0) ? 32'h0 : 32'hffff_ffff;
      apply_op((k < 2) ? OP_CLZ : OP_CLO, a, '0);
      check_alu((k < 2) ? OP_CLZ : OP_CLO, a, '0);
    end
  endtask

  task automatic test_overflow();
    word_t a [3];
    word_t b [3];
    a = '{32'h7fff_ffff, 32'h8000_0000, 32'h0000_0000};
    b = '{32'h0000_0001, 32'h0000_0001, 32'h8000_0000};
    for (int k = 0; k < 3; k++)
    begin
      apply_op((k == 0) ? OP_ADD : OP_SUB, a[k], b[k]);
      check_flag("ov_o on trapping add/sub", ov, 1'b1);
      check_flag("wreg_o on overflow", wreg_out, 1'b0);
      apply_op((k == 0) ? OP_ADDU : OP_SUBU, a[k], b[k]);
      check_flag("ov_o on unsigned add/sub", ov, 1'b0);
      check_flag("wreg_o on unsigned add/sub", wreg_out, 1'b1);
    end
  endtask

  task automatic test_traps();
    alu_op_e ops [6];
    word_t   a [3];
    word_t   b [3];
    ops = '{OP_TEQ, OP_TNE, OP_TGE, OP_TGEU, OP_TLT, OP_TLTU};
    // equal, then signed less but unsigned greater, then the reverse
    a = '{32'h0000_0005, 32'hffff_fffd, 32'h0000_0002};
    b = '{32'h0000_0005, 32'h0000_0002, 32'hffff_fffd};
    for (int k = 0; k < 6; k++)
      for (int p = 0; p < 3; p++)
      begin
        apply_op(ops[k], a[p], b[p]);
        check_flag($sformatf("%s trap_o, pair %0d", ops[k].name(), p), trap,
                   model_trap(ops[k], a[p], b[p]));
      end
  endtask

  task automatic test_mul_hilo();
    word_t  a;
    word_t  b;
    dword_t fwd;
    for (int n = 0; n < 2; n++)
    begin
      a = $urandom;
      b = $urandom;
      apply_op(OP_MULT, a, b);
      check_dword("MULT hi:lo", {hi_out, lo_out}, model_prod(1'b1, a, b));
      check_flag("MULT whilo_o", whilo, 1'b1);
      apply_op(OP_MULTU, a, b);
      check_dword("MULTU hi:lo", {hi_out, lo_out}, model_prod(1'b0, a, b));
      apply_op(OP_MUL, a, b);
      check_word("MUL wdata_o", wdata, word_t'(model_prod(1'b1, a, b)));
    end
    for (int m = 0; m < 4; m++)
    begin
      drive_hilo_sources(m[1], m[0]);
      fwd = model_fwd();
      a = $urandom;
      apply_op(OP_MFHI, a, '0);
      check_word("MFHI wdata_o", wdata, fwd[63:32]);
      apply_op(OP_MFLO, a, '0);
      check_word("MFLO wdata_o", wdata, fwd[31:0]);
      apply_op(OP_MTHI, a, '0);
      check_dword("MTHI hi:lo", {hi_out, lo_out}, {a, fwd[31:0]});
      check_flag("MTHI whilo_o", whilo, 1'b1);
      apply_op(OP_MTLO, a, '0);
      check_dword("MTLO hi:lo", {hi_out, lo_out}, {fwd[63:32], a});
    end
  endtask

  task automatic test_mac();
    alu_op_e ops [4];
    word_t   a;
    word_t   b;
    dword_t  prod;
    dword_t  exp;
    ops = '{OP_MADD, OP_MADDU, OP_MSUB, OP_MSUBU};
    drive_hilo_sources(1'b0, 1'b1);
    // back to back, so each one restarts from idle
    for (int k = 0; k < 4; k++)
    begin
      a = $urandom;
      b = $urandom;
      prod = model_prod(ops[k] inside {OP_MADD, OP_MSUB}, a, b);
      exp  = (ops[k] inside {OP_MSUB, OP_MSUBU}) ? model_fwd() - prod : model_fwd() + prod;
      apply_op(ops[k], a, b);
      check_flag($sformatf("%s stall_o, first cycle", ops[k].name()), stall, 1'b1);
      check_flag($sformatf("%s whilo_o, first cycle", ops[k].name()), whilo, 1'b0);
      hold_cycle();
      check_flag($sformatf("%s stall_o, second cycle", ops[k].name()), stall, 1'b0);
      check_flag($sformatf("%s whilo_o, second cycle", ops[k].name()), whilo, 1'b1);
      check_dword($sformatf("%s hi:lo", ops[k].name()), {hi_out, lo_out}, exp);
    end
  endtask

  initial
  begin
    rst_n     = 1'b0;
    aluop     = OP_NOP;
    alusel    = SEL_NOP;
    reg1      = '0;
    reg2      = '0;
    wd        = 5'd9;
    wreg      = 1'b0;
    hi        = '0;
    lo        = '0;
    mem_hi    = '0;
    mem_lo    = '0;
    mem_whilo = 1'b0;
    wb_hi     = '0;
    wb_lo     = '0;
    wb_whilo  = 1'b0;
    void'($urandom(32'hd25c_4af0));
    test_reset_quiet();
    test_alu();
    test_overflow();
    test_traps();
    test_mul_hilo();
    test_mac();
    if (u_ex_top.u_mul_acc.u_ex_properties.fail_cnt == 0)
    begin
      $display("Regression passed");
      $finish;
    end
    else
    begin
      $display("sequencer assertions failed during the run");
      $display("Regression failed");
      $fatal(1, "assertion failures");
    end
  end

  // watchdog sized from the cycle count of all tests
  initial
  begin
    #(CLK_PERIOD * (TEST_CYCLES + MARGIN_CYCLES));
    $display("timeout: tests did not finish within %0d cycles", TEST_CYCLES + MARGIN_CYCLES);
    $display("Regression failed");
    $fatal(1, "watchdog expired");
  end

endmodule
